/* design/mipsPkg.sv */
package mipsPkg;

    // primary opcodes, MIPS encodings where they exist
    typedef enum logic [5:0] {
        opR    = 6'h00,
        opBeq  = 6'h04,
        opBne  = 6'h05,
        opAddi = 6'h08,
        opAndi = 6'h0C,
        opOri  = 6'h0D,
        opXori = 6'h0E,
        opLui  = 6'h0F,
        opLw   = 6'h23,
        opSw   = 6'h2B,
        opHalt = 6'h3F
    } opcodeE;

    // r-type function field
    typedef enum logic [5:0] {
        fnSllv = 6'h04,
        fnSrlv = 6'h06,
        fnAdd  = 6'h20,
        fnSub  = 6'h22,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnXor  = 6'h26,
        fnNor  = 6'h27,
        fnSlt  = 6'h2A
    } functE;

    typedef enum logic [3:0] {
        aluAdd = 4'b0000,
        aluAnd = 4'b0001,
        aluOr  = 4'b0010,
        aluNor = 4'b0011,
        aluSub = 4'b0100,
        aluSlt = 4'b0101,
        aluSll = 4'b1000,
        aluSrl = 4'b1001,
        aluXor = 4'b1010,
        aluLui = 4'b1011
    } aluOpE;

    typedef enum logic [2:0] {
        stFetch,
        stDecode,
        stExecute,
        stMemory,
        stWriteback,
        stHalted
    } stateE;

endpackage

/* design/ctrlIf.sv */
`timescale 1ns/100ps

interface ctrlIf (
    input logic clk,
    input logic arstN
);
    mipsPkg::aluOpE aluOp;
    logic           aluSrcImm;
    logic           zeroExtend;
    logic           regWrite;
    logic           destIsRt;
    logic           memToReg;
    logic           irLoad;
    logic           pcAdvance;
    logic           branchTaken;

    modport ctrl (
        output aluOp, aluSrcImm, zeroExtend, regWrite, destIsRt,
        output memToReg, irLoad, pcAdvance, branchTaken
    );
    modport pc  (input pcAdvance, branchTaken);
    modport ops (input aluSrcImm, zeroExtend, destIsRt, memToReg, irLoad);
    modport rf  (input regWrite);
    // execute strobe and clock come along for the opcode check
    modport alu (input clk, arstN, aluOp, pcAdvance);

endinterface

/* design/alu32b.sv */
`timescale 1ns/100ps

module alu32b (
    ctrlIf.alu          ctrl,
    input  logic [31:0] leftOperand,
    input  logic [31:0] rightOperand,
    output logic [31:0] aluResult,
    output logic        zero
);
    logic        isSub;
    logic [31:0] rightSel;
    logic [31:0] addSubResult;
    logic        overflow;
    logic        lessThan;
    logic [31:0] shiftLeftResult;
    logic [31:0] shiftRightResult;
    logic [31:0] shiftLeft16Result;

    // slt reuses the subtractor
    assign isSub = (ctrl.aluOp == mipsPkg::aluSub) || (ctrl.aluOp == mipsPkg::aluSlt);
    assign rightSel = isSub ? ~rightOperand : rightOperand;
    assign addSubResult = leftOperand + rightSel + {31'b0, isSub};

    // signed compare, corrected for overflow
    assign overflow = (leftOperand[31] != rightOperand[31])
                   && (addSubResult[31] != leftOperand[31]);
    assign lessThan = addSubResult[31] ^ overflow;

    // shift amount comes from the left operand
    assign shiftLeftResult   = rightOperand << leftOperand[4:0];
    assign shiftRightResult  = rightOperand >> leftOperand[4:0];
    assign shiftLeft16Result = rightOperand << 16;

    always_comb begin
        case (ctrl.aluOp)
            mipsPkg::aluAdd: aluResult = addSubResult;
            mipsPkg::aluSub: aluResult = addSubResult;
            mipsPkg::aluAnd: aluResult = leftOperand & rightOperand;
            mipsPkg::aluOr:  aluResult = leftOperand | rightOperand;
            mipsPkg::aluNor: aluResult = ~(leftOperand | rightOperand);
            mipsPkg::aluXor: aluResult = leftOperand ^ rightOperand;
            mipsPkg::aluSlt: aluResult = {31'b0, lessThan};
            mipsPkg::aluSll: aluResult = shiftLeftResult;
            mipsPkg::aluSrl: aluResult = shiftRightResult;
            mipsPkg::aluLui: aluResult = shiftLeft16Result;
            default:         aluResult = 32'b0;
        endcase
    end

    assign zero = ~|aluResult;

    // decoder must hand over a defined operation whenever execute commits
    aluOpDefined: assert property (
        @(posedge ctrl.clk) disable iff (!ctrl.arstN)
        ctrl.pcAdvance |-> ctrl.aluOp inside {
            mipsPkg::aluAdd, mipsPkg::aluSub, mipsPkg::aluAnd, mipsPkg::aluOr,
            mipsPkg::aluNor, mipsPkg::aluSlt, mipsPkg::aluSll, mipsPkg::aluSrl,
            mipsPkg::aluXor, mipsPkg::aluLui
        }
    ) else $error("alu32b: undefined aluOp during execute");

endmodule

/* design/regFile.sv */
`timescale 1ns/100ps

module regFile (
    input  logic        clk,
    input  logic        arstN,
    ctrlIf.rf           ctrl,
    input  logic [4:0]  rsAddr,
    input  logic [4:0]  rtAddr,
    input  logic [4:0]  wrAddr,
    input  logic [31:0] wrData,
    output logic [31:0] rsData,
    output logic [31:0] rtData
);
    logic [31:0] regs [32];

    // register zero is never written
    always_ff @(posedge clk) begin
        if (ctrl.regWrite && (wrAddr != 5'd0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    assign rsData = (rsAddr == 5'd0) ? 32'b0 : regs[rsAddr];
    assign rtData = (rtAddr == 5'd0) ? 32'b0 : regs[rtAddr];

    // destination comes from the instruction register in operandPath
    wrAddrKnown: assert property (
        @(posedge clk) disable iff (!arstN)
        ctrl.regWrite |-> !$isunknown(wrAddr)
    ) else $error("regFile: write with unknown address");

endmodule

/* design/programCounter.sv */
`timescale 1ns/100ps

module programCounter #(
    parameter int pcWidth = 10
) (
    input  logic               clk,
    input  logic               arstN,
    ctrlIf.pc                  ctrl,
    input  logic [15:0]        branchOffset,
    output logic [pcWidth-1:0] pc
);
    logic [pcWidth-1:0] offsetExt;
    logic [pcWidth-1:0] pcInc;
    logic [pcWidth-1:0] pcNext;

    // word offset, sign extended or cut to the address width
    assign offsetExt = pcWidth'($signed(branchOffset));
    assign pcInc     = pc + pcWidth'(1);
    assign pcNext    = ctrl.branchTaken ? (pcInc + offsetExt) : pcInc;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (ctrl.pcAdvance) begin
            pc <= pcNext;
        end
    end

    // a taken branch without the advance strobe would be lost
    branchWithAdvance: assert property (
        @(posedge clk) disable iff (!arstN)
        ctrl.branchTaken |-> ctrl.pcAdvance
    ) else $error("programCounter: branchTaken without pcAdvance");

endmodule

/* design/operandPath.sv */
`timescale 1ns/100ps

module operandPath #(
    parameter int pcWidth = 10
) (
    input  logic               clk,
    input  logic               arstN,
    ctrlIf.ops                 ctrl,
    input  logic [31:0]        imemData,
    input  logic [31:0]        rsData,
    input  logic [31:0]        rtData,
    input  logic [31:0]        aluResult,
    input  logic [31:0]        dmemRdata,
    output mipsPkg::opcodeE    opcode,
    output mipsPkg::functE     funct,
    output logic [4:0]         rsAddr,
    output logic [4:0]         rtAddr,
    output logic [4:0]         wrAddr,
    output logic [31:0]        wrData,
    output logic [31:0]        leftOperand,
    output logic [31:0]        rightOperand,
    output logic [15:0]        branchOffset,
    output logic [pcWidth-1:0] dmemAddr
);
    logic [31:0] instr;
    logic [31:0] immExt;
    logic [31:0] aluOut;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            instr <= 32'b0;
        end else if (ctrl.irLoad) begin
            instr <= imemData;
        end
    end

    // held into the memory cycle as the word address
    always_ff @(posedge clk) begin
        aluOut <= aluResult;
    end

    assign opcode       = mipsPkg::opcodeE'(instr[31:26]);
    assign funct        = mipsPkg::functE'(instr[5:0]);
    assign rsAddr       = instr[25:21];
    assign rtAddr       = instr[20:16];
    assign branchOffset = instr[15:0];

    assign immExt = ctrl.zeroExtend ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

    assign leftOperand  = rsData;
    assign rightOperand = ctrl.aluSrcImm ? immExt : rtData;
    assign wrAddr       = ctrl.destIsRt ? instr[20:16] : instr[15:11];
    assign wrData       = ctrl.memToReg ? dmemRdata : aluResult;
    assign dmemAddr     = aluOut[pcWidth-1:0];

endmodule

/* design/controlUnit.sv */
`timescale 1ns/100ps

module controlUnit (
    input  logic            clk,
    input  logic            arstN,
    ctrlIf.ctrl             ctrl,
    input  mipsPkg::opcodeE opcode,
    input  mipsPkg::functE  funct,
    input  logic            zero,
    output logic            imemRead,
    output logic            dmemRead,
    output logic            dmemWrite,
    output logic            halted
);
    mipsPkg::stateE state;
    mipsPkg::stateE stateNext;
    logic           running;
    logic           isLoad;
    logic           isStore;
    logic           isBranch;
    logic           isStop;
    logic           writesReg;

    // running holds off the first fetch for one cycle after reset
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state   <= mipsPkg::stFetch;
            running <= 1'b0;
        end else begin
            state   <= stateNext;
            running <= 1'b1;
        end
    end

    // decode of the instruction register
    always_comb begin
        ctrl.aluOp      = mipsPkg::aluAdd;
        ctrl.aluSrcImm  = 1'b0;
        ctrl.zeroExtend = 1'b0;
        ctrl.destIsRt   = 1'b1;
        ctrl.memToReg   = 1'b0;
        isLoad          = 1'b0;
        isStore         = 1'b0;
        isBranch        = 1'b0;
        isStop          = 1'b0;
        writesReg       = 1'b0;
        case (opcode)
            mipsPkg::opR: begin
                ctrl.destIsRt = 1'b0;
                writesReg     = 1'b1;
                case (funct)
                    mipsPkg::fnAdd:  ctrl.aluOp = mipsPkg::aluAdd;
                    mipsPkg::fnSub:  ctrl.aluOp = mipsPkg::aluSub;
                    mipsPkg::fnAnd:  ctrl.aluOp = mipsPkg::aluAnd;
                    mipsPkg::fnOr:   ctrl.aluOp = mipsPkg::aluOr;
                    mipsPkg::fnNor:  ctrl.aluOp = mipsPkg::aluNor;
                    mipsPkg::fnXor:  ctrl.aluOp = mipsPkg::aluXor;
                    mipsPkg::fnSlt:  ctrl.aluOp = mipsPkg::aluSlt;
                    mipsPkg::fnSllv: ctrl.aluOp = mipsPkg::aluSll;
                    mipsPkg::fnSrlv: ctrl.aluOp = mipsPkg::aluSrl;
                    default:         isStop = 1'b1;
                endcase
            end
            mipsPkg::opAddi, mipsPkg::opAndi, mipsPkg::opOri,
            mipsPkg::opXori, mipsPkg::opLui: begin
                ctrl.aluSrcImm  = 1'b1;
                ctrl.zeroExtend = (opcode != mipsPkg::opAddi);
                writesReg       = 1'b1;
                case (opcode)
                    mipsPkg::opAndi: ctrl.aluOp = mipsPkg::aluAnd;
                    mipsPkg::opOri:  ctrl.aluOp = mipsPkg::aluOr;
                    mipsPkg::opXori: ctrl.aluOp = mipsPkg::aluXor;
                    mipsPkg::opLui:  ctrl.aluOp = mipsPkg::aluLui;
                    default:         ctrl.aluOp = mipsPkg::aluAdd;
                endcase
            end
            mipsPkg::opLw: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.memToReg  = 1'b1;
                isLoad         = 1'b1;
                writesReg      = 1'b1;
            end
            mipsPkg::opSw: begin
                ctrl.aluSrcImm = 1'b1;
                isStore        = 1'b1;
            end
            mipsPkg::opBeq, mipsPkg::opBne: begin
                ctrl.aluOp = mipsPkg::aluSub;
                isBranch   = 1'b1;
            end
            // halt, and anything not recognised
            default: isStop = 1'b1;
        endcase
    end

    always_comb begin
        stateNext = state;
        case (state)
            mipsPkg::stFetch:     if (running) stateNext = mipsPkg::stDecode;
            mipsPkg::stDecode:    stateNext = mipsPkg::stExecute;
            mipsPkg::stExecute: begin
                if (isStop) begin
                    stateNext = mipsPkg::stHalted;
                end else if (isLoad || isStore) begin
                    stateNext = mipsPkg::stMemory;
                end else if (isBranch) begin
                    stateNext = mipsPkg::stFetch;
                end else begin
                    stateNext = mipsPkg::stWriteback;
                end
            end
            mipsPkg::stMemory:    stateNext = isLoad ? mipsPkg::stWriteback : mipsPkg::stFetch;
            mipsPkg::stWriteback: stateNext = mipsPkg::stFetch;
            mipsPkg::stHalted:    stateNext = mipsPkg::stHalted;
            default:              stateNext = mipsPkg::stFetch;
        endcase
    end

    assign imemRead         = (state == mipsPkg::stFetch) && running;
    assign ctrl.irLoad      = (state == mipsPkg::stDecode);
    assign ctrl.pcAdvance   = (state == mipsPkg::stExecute) && !isStop;
    // beq wants equal operands, bne wants them different
    assign ctrl.branchTaken = (state == mipsPkg::stExecute) && isBranch
                           && ((opcode == mipsPkg::opBeq) ? zero : !zero);
    assign ctrl.regWrite    = (state == mipsPkg::stWriteback) && writesReg;
    assign dmemRead         = (state == mipsPkg::stMemory) && isLoad;
    assign dmemWrite        = (state == mipsPkg::stMemory) && isStore;
    assign halted           = (state == mipsPkg::stHalted);

    noReadWithWrite: assert property (
        @(posedge clk) disable iff (!arstN)
        !(dmemRead && dmemWrite)
    ) else $error("controlUnit: dmemRead and dmemWrite together");

endmodule

/* design/mipsCore.sv */
`timescale 1ns/100ps

module mipsCore #(
    parameter int pcWidth = 10
) (
    input  logic               clk,
    input  logic               arstN,
    output logic [pcWidth-1:0] imemAddr,
    output logic               imemRead,
    input  logic [31:0]        imemData,
    output logic [pcWidth-1:0] dmemAddr,
    output logic               dmemRead,
    output logic               dmemWrite,
    output logic [31:0]        dmemWdata,
    input  logic [31:0]        dmemRdata,
    output logic               halted
);
    mipsPkg::opcodeE opcode;
    mipsPkg::functE  funct;
    logic            zero;
    logic [4:0]      rsAddr;
    logic [4:0]      rtAddr;
    logic [4:0]      wrAddr;
    logic [31:0]     wrData;
    logic [31:0]     rsData;
    logic [31:0]     rtData;
    logic [31:0]     leftOperand;
    logic [31:0]     rightOperand;
    logic [31:0]     aluResult;
    logic [15:0]     branchOffset;

    ctrlIf ctrlBus (.clk(clk), .arstN(arstN));

    controlUnit ctrlUnit0 (
        .clk(clk), .arstN(arstN), .ctrl(ctrlBus.ctrl),
        .opcode(opcode), .funct(funct), .zero(zero),
        .imemRead(imemRead), .dmemRead(dmemRead), .dmemWrite(dmemWrite), .halted(halted)
    );

    programCounter #(.pcWidth(pcWidth)) pc0 (
        .clk(clk), .arstN(arstN), .ctrl(ctrlBus.pc),
        .branchOffset(branchOffset), .pc(imemAddr)
    );

    regFile regFile0 (
        .clk(clk), .arstN(arstN), .ctrl(ctrlBus.rf),
        .rsAddr(rsAddr), .rtAddr(rtAddr), .wrAddr(wrAddr), .wrData(wrData),
        .rsData(rsData), .rtData(rtData)
    );

    operandPath #(.pcWidth(pcWidth)) ops0 (
        .clk(clk), .arstN(arstN), .ctrl(ctrlBus.ops),
        .imemData(imemData), .rsData(rsData), .rtData(rtData),
        .aluResult(aluResult), .dmemRdata(dmemRdata),
        .opcode(opcode), .funct(funct),
        .rsAddr(rsAddr), .rtAddr(rtAddr), .wrAddr(wrAddr), .wrData(wrData),
        .leftOperand(leftOperand), .rightOperand(rightOperand),
        .branchOffset(branchOffset), .dmemAddr(dmemAddr)
    );

    alu32b alu0 (
        .ctrl(ctrlBus.alu), .leftOperand(leftOperand), .rightOperand(rightOperand),
        .aluResult(aluResult), .zero(zero)
    );

    // store data is rt straight from the register file
    assign dmemWdata = rtData;

endmodule

/* verification/clockGen.sv */
`timescale 1ns/100ps

module clockGen (
    output logic clk,
    output logic arstN
);
    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // held for 8 cycles, released on a falling edge
    initial begin
        arstN = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
    end

endmodule

/* verification/tbMemory.sv */
`timescale 1ns/100ps

module tbMemory #(
    parameter int pcWidth = 10
) (
    input  logic               clk,
    input  logic [pcWidth-1:0] imemAddr,
    input  logic               imemRead,
    output logic [31:0]        imemData,
    input  logic [pcWidth-1:0] dmemAddr,
    input  logic               dmemRead,
    input  logic               dmemWrite,
    input  logic [31:0]        dmemWdata,
    output logic [31:0]        dmemRdata
);
    // contents are loaded by the testbench top
    logic [31:0] imem [2**pcWidth];
    logic [31:0] dmem [2**pcWidth];

    initial begin
        imemData  = 32'b0;
        dmemRdata = 32'b0;
    end

    // one-cycle read latency on both ports
    always @(posedge clk) begin
        if (imemRead) begin
            imemData <= imem[imemAddr];
        end
        if (dmemRead) begin
            dmemRdata <= dmem[dmemAddr];
        end
        if (dmemWrite) begin
            dmem[dmemAddr] <= dmemWdata;
        end
    end

endmodule

/* verification/coreTb.sv */
`timescale 1ns/100ps

module coreTb;
    localparam int pcWidth     = 10;
    localparam int depth       = 2**pcWidth;
    localparam int resultBase  = 16;
    localparam int poisonAddr  = 100;
    localparam int haltTimeout = 2000;

    logic               clk;
    logic               arstN;
    logic [pcWidth-1:0] imemAddr;
    logic               imemRead;
    logic [31:0]        imemData;
    logic [pcWidth-1:0] dmemAddr;
    logic               dmemRead;
    logic               dmemWrite;
    logic [31:0]        dmemWdata;
    logic [31:0]        dmemRdata;
    logic               halted;

    // expected value per store address
    // test 0 marks an address that no store may reach
    logic [31:0] expVal [depth];
    int          expTest [depth];
    bit          written [depth];
    int          testErrors [1:6];
    int          progLen = 0;
    int          storeAddr = resultBase;
    int          expectedStores = 0;
    int          storeCount = 0;
    bit          fetchSeen = 1'b0;
    bit          timedOut = 1'b0;
    int          cycles;
    int          passCount;
    logic [31:0] seed;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] opNeg;
    logic [31:0] opPos;

    clockGen clk0 (.clk(clk), .arstN(arstN));

    tbMemory #(.pcWidth(pcWidth)) mem0 (
        .clk(clk), .imemAddr(imemAddr), .imemRead(imemRead), .imemData(imemData),
        .dmemAddr(dmemAddr), .dmemRead(dmemRead), .dmemWrite(dmemWrite),
        .dmemWdata(dmemWdata), .dmemRdata(dmemRdata)
    );

    mipsCore #(.pcWidth(pcWidth)) dut0 (
        .clk(clk), .arstN(arstN), .imemAddr(imemAddr), .imemRead(imemRead),
        .imemData(imemData), .dmemAddr(dmemAddr), .dmemRead(dmemRead),
        .dmemWrite(dmemWrite), .dmemWdata(dmemWdata), .dmemRdata(dmemRdata),
        .halted(halted)
    );

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rType(input logic [5:0] fn, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd);
        return {mipsPkg::opR, rs, rt, rd, 5'b0, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic emit(input logic [31:0] instr);
        mem0.imem[progLen] = instr;
        progLen++;
    endtask

    task automatic storeReg(input logic [4:0] rt, input logic [31:0] expected, input int testId);
        emit(iType(mipsPkg::opSw, 5'd0, rt, 16'(storeAddr)));
        expVal[storeAddr]  = expected;
        expTest[storeAddr] = testId;
        storeAddr++;
        expectedStores++;
    endtask

    task automatic flagError(input int testId, input string msg);
        testErrors[testId]++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    task automatic storeMismatch(input logic [pcWidth-1:0] addr, input logic [31:0] data);
        if (expTest[addr] == 0) begin
            flagError(4, $sformatf("unexpected store of %h to address %0d", data, addr));
        end else begin
            flagError(expTest[addr], $sformatf("address %0d got %h, expected %h",
                                               addr, data, expVal[addr]));
        end
    endtask

    task automatic reportTest(input int testId, input string name);
        if (testErrors[testId] == 0) begin
            $display("test %0d %s: ok", testId, name);
        end else begin
            $display("test %0d %s: %0d errors", testId, name, testErrors[testId]);
        end
    endtask

    always @(posedge clk) begin
        if (arstN && imemRead) begin
            fetchSeen <= 1'b1;
        end
        if (arstN && dmemWrite) begin
            storeCount <= storeCount + 1;
            written[dmemAddr] <= 1'b1;
        end
    end

    storeMatches: assert property (
        @(posedge clk) disable iff (!arstN)
        dmemWrite |-> (expTest[dmemAddr] != 0) && (dmemWdata == expVal[dmemAddr])
    ) else storeMismatch($sampled(dmemAddr), $sampled(dmemWdata));

    resetQuiet: assert property (
        @(negedge clk) !arstN |-> !dmemRead && !dmemWrite && !halted
    ) else flagError(5, "strobe or halted high during reset");

    releaseQuiet: assert property (
        @(posedge clk) $rose(arstN) |=> !dmemRead && !dmemWrite && !halted
    ) else flagError(5, "strobe or halted high on first cycle after reset");

    firstFetchAtZero: assert property (
        @(posedge clk) disable iff (!arstN)
        (imemRead && !fetchSeen) |-> imemAddr == '0
    ) else flagError(5, "first fetch not at word 0");

    haltHolds: assert property (
        @(posedge clk) disable iff (!arstN) halted |=> halted
    ) else flagError(6, "halted dropped");

    haltQuiet: assert property (
        @(posedge clk) disable iff (!arstN) halted |-> !imemRead && !dmemRead && !dmemWrite
    ) else flagError(6, "strobe after halt");

    initial begin
        // unused imem words halt and dmem words carry an address pattern
        for (int a = 0; a < depth; a++) begin
            mem0.imem[a] = {mipsPkg::opHalt, 26'(a)};
            mem0.dmem[a] = 32'hDA7A0000 ^ 32'(a);
        end
        seed  = 32'd24397;
        seed  = lcgNext(seed);
        opA   = seed;
        seed  = lcgNext(seed);
        opB   = seed;
        seed  = lcgNext(seed);
        opNeg = seed | 32'h80000000;
        seed  = lcgNext(seed);
        opPos = seed & 32'h7FFFFFFF;
        mem0.dmem[0] = opA;
        mem0.dmem[1] = opB;
        mem0.dmem[2] = opNeg;
        mem0.dmem[3] = opPos;

        emit(iType(mipsPkg::opLw, 5'd0, 5'd1, 16'd0));
        emit(iType(mipsPkg::opLw, 5'd0, 5'd2, 16'd1));
        emit(iType(mipsPkg::opLw, 5'd0, 5'd3, 16'd2));
        emit(iType(mipsPkg::opLw, 5'd0, 5'd4, 16'd3));
        emit(rType(mipsPkg::fnAdd, 5'd1, 5'd2, 5'd5));
        storeReg(5'd5, opA + opB, 1);
        emit(rType(mipsPkg::fnSub, 5'd1, 5'd2, 5'd5));
        storeReg(5'd5, opA - opB, 1);
        emit(rType(mipsPkg::fnAnd, 5'd1, 5'd2, 5'd5));
        storeReg(5'd5, opA & opB, 1);
        emit(rType(mipsPkg::fnOr, 5'd1, 5'd2, 5'd5));
        storeReg(5'd5, opA | opB, 1);
        emit(rType(mipsPkg::fnNor, 5'd1, 5'd2, 5'd5));
        storeReg(5'd5, ~(opA | opB), 1);
        emit(rType(mipsPkg::fnXor, 5'd1, 5'd2, 5'd5));
        storeReg(5'd5, opA ^ opB, 1);
        // slt with mixed signs both ways and then the random pair
        emit(rType(mipsPkg::fnSlt, 5'd3, 5'd4, 5'd5));
        storeReg(5'd5, {31'b0, $signed(opNeg) < $signed(opPos)}, 2);
        emit(rType(mipsPkg::fnSlt, 5'd4, 5'd3, 5'd5));
        storeReg(5'd5, {31'b0, $signed(opPos) < $signed(opNeg)}, 2);
        emit(rType(mipsPkg::fnSlt, 5'd1, 5'd2, 5'd5));
        storeReg(5'd5, {31'b0, $signed(opA) < $signed(opB)}, 2);
        // shift amount in rs and value in rt
        emit(rType(mipsPkg::fnSllv, 5'd1, 5'd2, 5'd5));
        storeReg(5'd5, opB << opA[4:0], 2);
        emit(rType(mipsPkg::fnSrlv, 5'd1, 5'd2, 5'd5));
        storeReg(5'd5, opB >> opA[4:0], 2);
        emit(iType(mipsPkg::opAddi, 5'd1, 5'd5, 16'hFFFD));
        storeReg(5'd5, opA + 32'hFFFFFFFD, 3);
        emit(iType(mipsPkg::opAndi, 5'd1, 5'd5, 16'h8F0F));
        storeReg(5'd5, opA & 32'h00008F0F, 3);
        emit(iType(mipsPkg::opOri, 5'd1, 5'd5, 16'h8001));
        storeReg(5'd5, opA | 32'h00008001, 3);
        emit(iType(mipsPkg::opXori, 5'd1, 5'd5, 16'hF00F));
        storeReg(5'd5, opA ^ 32'h0000F00F, 3);
        emit(iType(mipsPkg::opLui, 5'd0, 5'd5, 16'h9ABC));
        storeReg(5'd5, 32'h9ABC0000, 3);
        emit(iType(mipsPkg::opAddi, 5'd1, 5'd0, 16'd5));
        storeReg(5'd0, 32'h0, 3);
        // taken branches skip the poison store
        emit(iType(mipsPkg::opBeq, 5'd1, 5'd1, 16'd1));
        emit(iType(mipsPkg::opSw, 5'd0, 5'd1, 16'(poisonAddr)));
        emit(iType(mipsPkg::opBeq, 5'd3, 5'd4, 16'd1));
        storeReg(5'd3, opNeg, 4);
        emit(iType(mipsPkg::opBne, 5'd3, 5'd3, 16'd1));
        storeReg(5'd4, opPos, 4);
        emit(iType(mipsPkg::opBne, 5'd3, 5'd4, 16'd1));
        emit(iType(mipsPkg::opSw, 5'd0, 5'd1, 16'(poisonAddr)));
        emit({mipsPkg::opHalt, 26'b0});

        cycles = 0;
        while (!fetchSeen && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
        if (!fetchSeen) begin
            timedOut = 1'b1;
            $display("timeout: no instruction fetch within 100 cycles");
        end
        reportTest(5, "reset");

        if (!timedOut) begin
            cycles = 0;
            while (!halted && cycles < haltTimeout) begin
                @(negedge clk);
                cycles++;
            end
            if (!halted) begin
                timedOut = 1'b1;
                $display("timeout: halted did not rise within %0d cycles", haltTimeout);
            end
        end

        if (!timedOut) begin
            // a few cycles in the halted state
            repeat (4) @(negedge clk);
            for (int a = 0; a < depth; a++) begin
                assert (expTest[a] == 0 || written[a])
                else flagError(expTest[a], $sformatf("no store reached address %0d", a));
            end
            reportTest(1, "register alu");
            reportTest(2, "slt and shifts");
            reportTest(3, "immediates");
            reportTest(4, "branches");
            assert (storeCount == expectedStores)
            else flagError(6, $sformatf("%0d stores, expected %0d", storeCount, expectedStores));
            reportTest(6, "halt");
        end

        passCount = 0;
        for (int t = 1; t <= 6; t++) begin
            if (testErrors[t] == 0) begin
                passCount++;
            end
        end
        $display("summary: %0d passed, %0d failed", passCount, 6 - passCount);
        if (timedOut || passCount != 6) begin
            $display("tests failed");
        end else begin
            $display("all tests passed");
        end
        $finish;
    end

endmodule

/* filelist.f */
design/mipsPkg.sv
design/ctrlIf.sv
design/alu32b.sv
design/regFile.sv
design/programCounter.sv
design/operandPath.sv
design/controlUnit.sv
design/mipsCore.sv
verification/clockGen.sv
verification/tbMemory.sv
verification/coreTb.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - files:
      - design/mipsPkg.sv
      - design/ctrlIf.sv
      - design/alu32b.sv
      - design/regFile.sv
      - design/programCounter.sv
      - design/operandPath.sv
      - design/controlUnit.sv
      - design/mipsCore.sv
  - target: test
    files:
      - verification/clockGen.sv
      - verification/tbMemory.sv
      - verification/coreTb.sv
